// ==== verilog/firmat_macros.svh ====
`ifndef FIRMAT_MACROS_SVH
`define FIRMAT_MACROS_SVH

// stream and result word width
`define FIRMAT_DATA_W 32

// fir sizes
`define FIR_TAPS 11
`define FIR_SAMPLES 64

// lanes in the shared multiply-accumulate array
`define MAC_LANES 11

// matrix job sizes
`define MAT_DIM 4
`define MAT_WORDS 32
`define MAT_RESULTS 16

`endif

// ==== verilog/firmat_pkg.sv ====
`include "firmat_macros.svh"

package firmat_pkg;

    // one stream or result word
    typedef logic [`FIRMAT_DATA_W-1:0] data_t;

    // operand vector for the array, lane 0 in the low word
    typedef data_t [`MAC_LANES-1:0] lane_vec_t;

endpackage

// ==== verilog/fir_engine.sv ====
`timescale 1ns/10ps
`include "firmat_macros.svh"

module fir_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ap_start_fir,
    input  logic                  fir_ss_tvalid,
    input  firmat_pkg::data_t     fir_ss_tdata,
    output logic                  fir_ss_tready,
    output logic                  fir_w_fifo_en,
    output logic                  done_fir,
    output logic                  fir_oper,
    output firmat_pkg::lane_vec_t fir_opa,
    output firmat_pkg::lane_vec_t fir_opb
);
    import firmat_pkg::*;

    localparam int CNT_W = $clog2(`FIR_SAMPLES);
    localparam int PTR_W = $clog2(`FIR_TAPS);

    typedef enum logic [1:0] {
        FIR_IDLE,
        FIR_READ,
        FIR_STORE,
        FIR_OPER
    } fir_state_t;

    fir_state_t       state_q;
    fir_state_t       state_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] ptr_d;
    logic             ready_d;
    logic             xfer;
    logic             tap_we;
    logic             hist_we;
    logic             hist_clr;
    data_t            tap_q  [`FIR_TAPS];
    data_t            hist_q [`FIR_TAPS];

    // history slot of x[n-k], newest sample sits just above the store pointer
    function automatic logic [PTR_W-1:0] hist_slot(input logic [PTR_W-1:0] ptr, input int k);
        int slot;
        slot = int'(ptr) + 1 + k;
        if (slot >= `FIR_TAPS) begin
            slot = slot - `FIR_TAPS;
        end
        return PTR_W'(slot);
    endfunction

    assign xfer = fir_ss_tvalid && fir_ss_tready;

    always_comb begin
        state_d       = state_q;
        cnt_d         = cnt_q;
        ptr_d         = ptr_q;
        ready_d       = 1'b0;
        tap_we        = 1'b0;
        hist_we       = 1'b0;
        hist_clr      = 1'b0;
        fir_w_fifo_en = 1'b0;
        done_fir      = 1'b0;
        case (state_q)
            FIR_IDLE: begin
                if (ap_start_fir) begin
                    ready_d  = 1'b1;
                    hist_clr = 1'b1;
                    cnt_d    = '0;
                    ptr_d    = PTR_W'(`FIR_TAPS - 1);
                    state_d  = FIR_READ;
                end
            end
            FIR_READ: begin
                ready_d = 1'b1;
                if (xfer) begin
                    tap_we = 1'b1;
                    if (cnt_q == CNT_W'(`FIR_TAPS - 1)) begin
                        cnt_d   = '0;
                        state_d = FIR_STORE;
                    end else begin
                        cnt_d = cnt_q + 1'b1;
                    end
                end
            end
            FIR_STORE: begin
                if (xfer) begin
                    hist_we = 1'b1;
                    ptr_d   = (ptr_q == '0) ? PTR_W'(`FIR_TAPS - 1) : ptr_q - 1'b1;
                    state_d = FIR_OPER;
                end else begin
                    ready_d = 1'b1;
                end
            end
            FIR_OPER: begin
                fir_w_fifo_en = 1'b1;
                if (cnt_q == CNT_W'(`FIR_SAMPLES - 1)) begin
                    done_fir = 1'b1;
                    cnt_d    = '0;
                    state_d  = FIR_IDLE;
                end else begin
                    cnt_d   = cnt_q + 1'b1;
                    ready_d = 1'b1;
                    state_d = FIR_STORE;
                end
            end
            default: state_d = FIR_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q       <= FIR_IDLE;
            cnt_q         <= '0;
            ptr_q         <= PTR_W'(`FIR_TAPS - 1);
            fir_ss_tready <= 1'b0;
        end else begin
            state_q       <= state_d;
            cnt_q         <= cnt_d;
            ptr_q         <= ptr_d;
            fir_ss_tready <= ready_d;
        end
    end

    // tap store and circular sample history
    always_ff @(posedge clk) begin
        if (tap_we) begin
            tap_q[cnt_q[PTR_W-1:0]] <= fir_ss_tdata;
        end
        if (hist_clr) begin
            for (int k = 0; k < `FIR_TAPS; k++) begin
                hist_q[k] <= '0;
            end
        end else if (hist_we) begin
            hist_q[ptr_q] <= fir_ss_tdata;
        end
    end

    assign fir_oper = (state_q == FIR_OPER);

    always_comb begin
        fir_opa = '0;
        fir_opb = '0;
        for (int k = 0; k < `MAC_LANES; k++) begin
            if (k < `FIR_TAPS) begin
                fir_opa[k] = tap_q[k];
                fir_opb[k] = hist_q[hist_slot(ptr_q, k)];
            end
        end
    end

    a_no_result_while_ready: assert property (@(posedge clk) disable iff (rst)
        fir_w_fifo_en |-> !fir_ss_tready);

endmodule

// ==== verilog/matmul_engine.sv ====
`timescale 1ns/10ps
`include "firmat_macros.svh"

module matmul_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ap_start_matmul,
    input  logic                  mat_ss_tvalid,
    input  firmat_pkg::data_t     mat_ss_tdata,
    output logic                  mat_ss_tready,
    output logic                  mat_w_fifo_en,
    output logic                  done_matmul,
    output logic                  mat_oper,
    output firmat_pkg::lane_vec_t mat_opa,
    output firmat_pkg::lane_vec_t mat_opb
);
    import firmat_pkg::*;

    localparam int WORD_W = $clog2(`MAT_WORDS);
    localparam int RES_W  = $clog2(`MAT_RESULTS);
    localparam int DIM_W  = $clog2(`MAT_DIM);
    localparam int B_BASE = `MAT_DIM * `MAT_DIM;

    typedef enum logic [1:0] {
        MAT_IDLE,
        MAT_READ,
        MAT_OPER
    } mat_state_t;

    mat_state_t        state_q;
    mat_state_t        state_d;
    logic [WORD_W-1:0] word_cnt_q;
    logic [WORD_W-1:0] word_cnt_d;
    logic [RES_W-1:0]  res_cnt_q;
    logic [RES_W-1:0]  res_cnt_d;
    logic              ready_d;
    logic              xfer;
    logic [DIM_W-1:0]  row_a;
    logic [DIM_W-1:0]  row_b;
    data_t             mat_q [`MAT_WORDS];

    assign xfer = mat_ss_tvalid && mat_ss_tready;

    always_comb begin
        state_d       = state_q;
        word_cnt_d    = word_cnt_q;
        res_cnt_d     = res_cnt_q;
        ready_d       = 1'b0;
        mat_w_fifo_en = 1'b0;
        done_matmul   = 1'b0;
        case (state_q)
            MAT_IDLE: begin
                if (ap_start_matmul) begin
                    ready_d    = 1'b1;
                    word_cnt_d = '0;
                    state_d    = MAT_READ;
                end
            end
            MAT_READ: begin
                ready_d = 1'b1;
                if (xfer) begin
                    if (word_cnt_q == WORD_W'(`MAT_WORDS - 1)) begin
                        ready_d   = 1'b0;
                        res_cnt_d = '0;
                        state_d   = MAT_OPER;
                    end else begin
                        word_cnt_d = word_cnt_q + 1'b1;
                    end
                end
            end
            MAT_OPER: begin
                mat_w_fifo_en = 1'b1;
                res_cnt_d     = res_cnt_q + 1'b1;
                if (res_cnt_q == RES_W'(`MAT_RESULTS - 1)) begin
                    done_matmul = 1'b1;
                    state_d     = MAT_IDLE;
                end
            end
            default: state_d = MAT_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q       <= MAT_IDLE;
            word_cnt_q    <= '0;
            res_cnt_q     <= '0;
            mat_ss_tready <= 1'b0;
        end else begin
            state_q       <= state_d;
            word_cnt_q    <= word_cnt_d;
            res_cnt_q     <= res_cnt_d;
            mat_ss_tready <= ready_d;
        end
    end

    // A then B, both row-major
    always_ff @(posedge clk) begin
        if (xfer) begin
            mat_q[word_cnt_q] <= mat_ss_tdata;
        end
    end

    assign mat_oper = (state_q == MAT_OPER);

    // i in the high counter bits, j in the low bits
    assign row_a = res_cnt_q[RES_W-1:DIM_W];
    assign row_b = res_cnt_q[DIM_W-1:0];

    always_comb begin
        mat_opa = '0;
        mat_opb = '0;
        for (int k = 0; k < `MAT_DIM; k++) begin
            mat_opa[k] = mat_q[int'(row_a) * `MAT_DIM + k];
            mat_opb[k] = mat_q[B_BASE + int'(row_b) * `MAT_DIM + k];
        end
    end

    a_no_result_while_ready: assert property (@(posedge clk) disable iff (rst)
        !(mat_ss_tready && mat_w_fifo_en));

endmodule

// ==== verilog/mac_array.sv ====
`timescale 1ns/10ps
`include "firmat_macros.svh"

module mac_array (
    input  logic                  clk,
    input  logic                  fir_oper,
    input  firmat_pkg::lane_vec_t fir_opa,
    input  firmat_pkg::lane_vec_t fir_opb,
    input  logic                  mat_oper,
    input  firmat_pkg::lane_vec_t mat_opa,
    input  firmat_pkg::lane_vec_t mat_opb,
    output firmat_pkg::data_t     firmat_data_out
);
    import firmat_pkg::*;

    lane_vec_t op_a;
    lane_vec_t op_b;
    data_t     prod [`MAC_LANES];

    // fir has priority, idle array sees zero operands
    always_comb begin
        if (fir_oper) begin
            op_a = fir_opa;
            op_b = fir_opb;
        end else if (mat_oper) begin
            op_a = mat_opa;
            op_b = mat_opb;
        end else begin
            op_a = '0;
            op_b = '0;
        end
    end

    // products and sum keep the low word only
    always_comb begin
        for (int k = 0; k < `MAC_LANES; k++) begin
            prod[k] = op_a[k] * op_b[k];
        end
    end

    always_comb begin
        firmat_data_out = '0;
        for (int k = 0; k < `MAC_LANES; k++) begin
            firmat_data_out = firmat_data_out + prod[k];
        end
    end

    a_one_engine_operating: assert property (@(posedge clk)
        !(fir_oper && mat_oper));

endmodule

// ==== verilog/firmat_top.sv ====
`timescale 1ns/10ps

module firmat_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              ap_start_fir,
    input  logic              fir_ss_tvalid,
    input  firmat_pkg::data_t fir_ss_tdata,
    output logic              fir_ss_tready,
    output logic              fir_w_fifo_en,
    output logic              done_fir,
    input  logic              ap_start_matmul,
    input  logic              mat_ss_tvalid,
    input  firmat_pkg::data_t mat_ss_tdata,
    output logic              mat_ss_tready,
    output logic              mat_w_fifo_en,
    output logic              done_matmul,
    output firmat_pkg::data_t firmat_data_out
);
    import firmat_pkg::*;

    logic      fir_oper;
    lane_vec_t fir_opa;
    lane_vec_t fir_opb;
    logic      mat_oper;
    lane_vec_t mat_opa;
    lane_vec_t mat_opb;

    fir_engine u_fir_engine (
        .clk           (clk),
        .rst           (rst),
        .ap_start_fir  (ap_start_fir),
        .fir_ss_tvalid (fir_ss_tvalid),
        .fir_ss_tdata  (fir_ss_tdata),
        .fir_ss_tready (fir_ss_tready),
        .fir_w_fifo_en (fir_w_fifo_en),
        .done_fir      (done_fir),
        .fir_oper      (fir_oper),
        .fir_opa       (fir_opa),
        .fir_opb       (fir_opb)
    );

    matmul_engine u_matmul_engine (
        .clk             (clk),
        .rst             (rst),
        .ap_start_matmul (ap_start_matmul),
        .mat_ss_tvalid   (mat_ss_tvalid),
        .mat_ss_tdata    (mat_ss_tdata),
        .mat_ss_tready   (mat_ss_tready),
        .mat_w_fifo_en   (mat_w_fifo_en),
        .done_matmul     (done_matmul),
        .mat_oper        (mat_oper),
        .mat_opa         (mat_opa),
        .mat_opb         (mat_opb)
    );

    // shared by both engines
    mac_array u_mac_array (
        .clk             (clk),
        .fir_oper        (fir_oper),
        .fir_opa         (fir_opa),
        .fir_opb         (fir_opb),
        .mat_oper        (mat_oper),
        .mat_opa         (mat_opa),
        .mat_opb         (mat_opb),
        .firmat_data_out (firmat_data_out)
    );

endmodule

// ==== tb/firmat_model.svh ====
`ifndef FIRMAT_MODEL_SVH
`define FIRMAT_MODEL_SVH

// y[n] = sum of tap[k] * x[n-k], samples before the run count as zero
function automatic void fir_model(
    input  data_t taps [`FIR_TAPS],
    input  data_t xs   [`FIR_SAMPLES],
    output data_t ys   [`FIR_SAMPLES]
);
    data_t acc;
    for (int n = 0; n < `FIR_SAMPLES; n++) begin
        acc = '0;
        for (int k = 0; k < `FIR_TAPS && k <= n; k++) begin
            acc = acc + taps[k] * xs[n - k];
        end
        ys[n] = acc;
    end
endfunction

// c[i][j] = sum of a[i][k] * b[j][k]
// words hold a then b, both row-major
function automatic void mat_model(
    input  data_t words [`MAT_WORDS],
    output data_t res   [`MAT_RESULTS]
);
    data_t acc;
    for (int i = 0; i < `MAT_DIM; i++) begin
        for (int j = 0; j < `MAT_DIM; j++) begin
            acc = '0;
            for (int k = 0; k < `MAT_DIM; k++) begin
                acc = acc + words[i * `MAT_DIM + k]
                          * words[`MAT_DIM * `MAT_DIM + j * `MAT_DIM + k];
            end
            res[i * `MAT_DIM + j] = acc;
        end
    end
endfunction

`endif

// ==== tb/firmat_tb.sv ====
`timescale 1ns/10ps
`include "firmat_macros.svh"

module firmat_tb;
    import firmat_pkg::*;

    `include "firmat_model.svh"

    localparam int CLK_HALF        = 4;
    localparam int TOTAL_WORDS     = 3 * (`FIR_TAPS + `FIR_SAMPLES) + 2 * `MAT_WORDS;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 4 + 200;

    logic  clk = 1'b0;
    logic  rst;
    logic  ap_start_fir;
    logic  fir_ss_tvalid;
    data_t fir_ss_tdata;
    logic  fir_ss_tready;
    logic  fir_w_fifo_en;
    logic  done_fir;
    logic  ap_start_matmul;
    logic  mat_ss_tvalid;
    data_t mat_ss_tdata;
    logic  mat_ss_tready;
    logic  mat_w_fifo_en;
    logic  done_matmul;
    data_t firmat_data_out;

    data_t lcg_state     = 32'h7738_53e5;
    string test_name     = "reset";
    data_t fir_exp[$];
    data_t mat_exp[$];
    int    fir_seen      = 0;
    int    mat_seen      = 0;
    logic  fir_done_seen = 1'b0;
    logic  mat_done_seen = 1'b0;
    logic  fir_done_prev = 1'b0;

    firmat_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .ap_start_fir    (ap_start_fir),
        .fir_ss_tvalid   (fir_ss_tvalid),
        .fir_ss_tdata    (fir_ss_tdata),
        .fir_ss_tready   (fir_ss_tready),
        .fir_w_fifo_en   (fir_w_fifo_en),
        .done_fir        (done_fir),
        .ap_start_matmul (ap_start_matmul),
        .mat_ss_tvalid   (mat_ss_tvalid),
        .mat_ss_tdata    (mat_ss_tdata),
        .mat_ss_tready   (mat_ss_tready),
        .mat_w_fifo_en   (mat_w_fifo_en),
        .done_matmul     (done_matmul),
        .firmat_data_out (firmat_data_out)
    );

    always #CLK_HALF clk = ~clk;

    function automatic data_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "level mismatch");
        end
    endtask

    // all calls start and end 1 ns after a rising edge
    task automatic pulse_start(input bit to_fir);
        if (to_fir) begin
            ap_start_fir = 1'b1;
        end else begin
            ap_start_matmul = 1'b1;
        end
        @(posedge clk);
        #1;
        ap_start_fir    = 1'b0;
        ap_start_matmul = 1'b0;
    endtask

    task automatic send_word(input bit to_fir, input data_t word);
        data_t r;
        int    gap;
        r   = next_rand();
        gap = int'(r[31:30]);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        if (to_fir) begin
            fir_ss_tvalid = 1'b1;
            fir_ss_tdata  = word;
        end else begin
            mat_ss_tvalid = 1'b1;
            mat_ss_tdata  = word;
        end
        // word moves on the rising edge after ready is seen high
        do begin
            @(negedge clk);
        end while (!(to_fir ? fir_ss_tready : mat_ss_tready));
        @(posedge clk);
        #1;
        fir_ss_tvalid = 1'b0;
        mat_ss_tvalid = 1'b0;
    endtask

    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_bit({test_name, " idle fir_ss_tready"}, 1'b0, fir_ss_tready);
            check_bit({test_name, " idle mat_ss_tready"}, 1'b0, mat_ss_tready);
            check_bit({test_name, " idle fir_w_fifo_en"}, 1'b0, fir_w_fifo_en);
            check_bit({test_name, " idle mat_w_fifo_en"}, 1'b0, mat_w_fifo_en);
            check_bit({test_name, " idle done_fir"}, 1'b0, done_fir);
            check_bit({test_name, " idle done_matmul"}, 1'b0, done_matmul);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_fir(input string name);
        data_t taps [`FIR_TAPS];
        data_t xs   [`FIR_SAMPLES];
        data_t ys   [`FIR_SAMPLES];
        for (int k = 0; k < `FIR_TAPS; k++) begin
            taps[k] = next_rand();
        end
        for (int n = 0; n < `FIR_SAMPLES; n++) begin
            xs[n] = next_rand();
        end
        fir_model(taps, xs, ys);
        test_name     = name;
        fir_seen      = 0;
        fir_done_seen = 1'b0;
        for (int n = 0; n < `FIR_SAMPLES; n++) begin
            fir_exp.push_back(ys[n]);
        end
        pulse_start(1'b1);
        for (int k = 0; k < `FIR_TAPS; k++) begin
            send_word(1'b1, taps[k]);
        end
        for (int n = 0; n < `FIR_SAMPLES; n++) begin
            send_word(1'b1, xs[n]);
        end
        while (!fir_done_seen) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic run_mat(input string name);
        data_t words [`MAT_WORDS];
        data_t res   [`MAT_RESULTS];
        for (int w = 0; w < `MAT_WORDS; w++) begin
            words[w] = next_rand();
        end
        mat_model(words, res);
        test_name     = name;
        mat_seen      = 0;
        mat_done_seen = 1'b0;
        for (int r = 0; r < `MAT_RESULTS; r++) begin
            mat_exp.push_back(res[r]);
        end
        pulse_start(1'b0);
        for (int w = 0; w < `MAT_WORDS; w++) begin
            send_word(1'b0, words[w]);
        end
        while (!mat_done_seen) begin
            @(posedge clk);
        end
        #1;
    endtask

    // result monitor samples mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (fir_done_prev) begin
                check_bit({test_name, " fir_ss_tready after done"}, 1'b0, fir_ss_tready);
            end
            fir_done_prev = done_fir;
            // array output rests at zero between results
            if (!fir_w_fifo_en && !mat_w_fifo_en) begin
                check_data({test_name, " idle firmat_data_out"}, '0, firmat_data_out);
            end
            check_bit({test_name, " done_fir"},
                      fir_w_fifo_en && fir_seen == `FIR_SAMPLES - 1, done_fir);
            if (fir_w_fifo_en) begin
                if (fir_exp.size() == 0) begin
                    abort_run("FIR result strobe while no result was expected");
                end else begin
                    check_data({test_name, " fir result"}, fir_exp.pop_front(),
                               firmat_data_out);
                    fir_seen++;
                    if (done_fir) begin
                        fir_done_seen = 1'b1;
                    end
                end
            end
            // matrix results come back to back
            if (mat_seen > 0 && mat_seen < `MAT_RESULTS) begin
                check_bit({test_name, " mat strobe run"}, 1'b1, mat_w_fifo_en);
            end
            check_bit({test_name, " done_matmul"},
                      mat_w_fifo_en && mat_seen == `MAT_RESULTS - 1, done_matmul);
            if (mat_w_fifo_en) begin
                if (mat_exp.size() == 0) begin
                    abort_run("matrix result strobe while no result was expected");
                end else begin
                    check_data({test_name, " mat result"}, mat_exp.pop_front(),
                               firmat_data_out);
                    mat_seen++;
                    if (done_matmul) begin
                        mat_done_seen = 1'b1;
                    end
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before all tests finished");
    end

    initial begin
        rst             = 1'b1;
        ap_start_fir    = 1'b0;
        fir_ss_tvalid   = 1'b0;
        fir_ss_tdata    = '0;
        ap_start_matmul = 1'b0;
        mat_ss_tvalid   = 1'b0;
        mat_ss_tdata    = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_check(8);
        run_fir("fir_run1");
        idle_check(3);
        run_fir("fir_run2");
        idle_check(3);
        run_mat("mat_job1");
        idle_check(3);
        run_fir("fir_after_mat");
        idle_check(3);
        run_mat("mat_after_fir");
        idle_check(3);
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== firmat.f ====
+incdir+verilog
+incdir+tb
verilog/firmat_pkg.sv
verilog/fir_engine.sv
verilog/matmul_engine.sv
verilog/mac_array.sv
verilog/firmat_top.sv
tb/firmat_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f firmat.f --top-module firmat_tb \
    -o firmat_sim > sim.log 2>&1 &&
    ./obj_dir/firmat_sim >> sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0
